/* Bender.yml */
package:
  name: eeprom_sys

sources:
  - src/i2c_pkg.sv
  - src/apb_pkg.sv
  - src/eeprom_i2c_master.sv
  - src/eeprom_arbiter.sv
  - src/apb_eeprom_regs.sv
  - src/boot_loader.sv
  - src/eeprom_sys_top.sv
  - target: test
    files:
      - test/eeprom_model.sv
      - test/tb_eeprom_sys.sv

/* src.f */
src/i2c_pkg.sv
src/apb_pkg.sv
src/eeprom_i2c_master.sv
src/eeprom_arbiter.sv
src/apb_eeprom_regs.sv
src/boot_loader.sv
src/eeprom_sys_top.sv
test/eeprom_model.sv
test/tb_eeprom_sys.sv

/* src/apb_eeprom_regs.sv */
`timescale 1ns/100ps
module apb_eeprom_regs import apb_pkg::*, i2c_pkg::*; (
    input  logic      CLK,
    input  logic      RESET,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_addr_t paddr,
    input  apb_data_t pwdata,
    output apb_data_t prdata,
    output logic      pready,
    output logic      pslverr,
    output logic      host_req,
    output logic      host_rd,
    output ee_addr_t  host_addr,
    output ee_data_t  host_wdata,
    input  logic      host_done,
    input  logic      rsp_nack,
    input  ee_data_t  rsp_rdata
);
    ee_addr_t addr_r;
    ee_data_t wdata_r;
    ee_data_t rdata_r;
    logic     nack_r;
    logic     done_r;
    logic     setup;
    logic     wr_access;

    assign setup     = psel && !penable;
    assign wr_access = psel && penable && pwrite && !pslverr;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            pready   <= 1'b0;
            pslverr  <= 1'b0;
            prdata   <= '0;
            addr_r   <= '0;
            wdata_r  <= '0;
            rdata_r  <= '0;
            nack_r   <= 1'b0;
            done_r   <= 1'b0;
            host_req <= 1'b0;
            host_rd  <= 1'b0;
        end
        else
        begin
            // response is ready for the access phase
            pready  <= setup;
            pslverr <= setup && pwrite && paddr == REG_CMD && host_req;

            if (setup)
            begin
                case (paddr)
                    REG_ADDR:   prdata <= apb_data_t'(addr_r);
                    REG_WDATA:  prdata <= apb_data_t'(wdata_r);
                    REG_CMD:    prdata <= {30'b0, host_rd, host_req};
                    REG_STATUS: prdata <= {29'b0, done_r, nack_r, host_req};
                    REG_RDATA:  prdata <= apb_data_t'(rdata_r);
                    default:    prdata <= '0;
                endcase
            end

            if (wr_access && paddr == REG_ADDR)
                addr_r <= pwdata[10:0];
            if (wr_access && paddr == REG_WDATA)
                wdata_r <= pwdata[7:0];

            if (wr_access && paddr == REG_CMD && pwdata[0])
            begin
                host_req <= 1'b1;
                host_rd  <= pwdata[1];
                nack_r   <= 1'b0;
                done_r   <= 1'b0;   // sticky until next go
            end
            else if (host_done)
            begin
                host_req <= 1'b0;
                nack_r   <= rsp_nack;
                done_r   <= 1'b1;
                if (host_rd)
                    rdata_r <= rsp_rdata;
            end
        end
    end

    // held steady for the arbiter until done
    always_ff @(posedge CLK)
    begin
        if (wr_access && paddr == REG_CMD && pwdata[0])
        begin
            host_addr  <= addr_r;
            host_wdata <= wdata_r;
        end
    end

    a_pready_access: assert property (@(posedge CLK) disable iff (RESET)
        pready |-> psel && penable)
        else $error("pready outside an APB access phase");

endmodule

/* src/apb_pkg.sv */
package apb_pkg;

    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // register map
    localparam apb_addr_t REG_ADDR   = 8'h00;
    localparam apb_addr_t REG_WDATA  = 8'h04;
    localparam apb_addr_t REG_CMD    = 8'h08;   // bit 0 go, bit 1 read
    localparam apb_addr_t REG_STATUS = 8'h0C;   // busy, nack, done
    localparam apb_addr_t REG_RDATA  = 8'h10;

endpackage

/* src/boot_loader.sv */
`timescale 1ns/100ps
module boot_loader import i2c_pkg::*; #(
    parameter int BOOT_BYTES = 4
) (
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    boot_done_in,
    input  ee_data_t                rsp_rdata,
    output logic                    boot_req,
    output ee_addr_t                boot_addr,
    output logic [BOOT_BYTES*8-1:0] boot_cfg,
    output logic                    boot_done
);
    localparam int IDX_W = (BOOT_BYTES > 1) ? $clog2(BOOT_BYTES) : 1;
    localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(BOOT_BYTES - 1);

    logic [IDX_W-1:0] idx;

    assign boot_addr = ee_addr_t'(idx);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            idx       <= '0;
            boot_req  <= 1'b0;
            boot_done <= 1'b0;
            boot_cfg  <= '0;
        end
        else if (boot_done_in)
        begin
            boot_cfg[idx*8 +: 8] <= rsp_rdata;   // nack leaves FF
            if (idx == IDX_LAST)
            begin
                boot_req  <= 1'b0;
                boot_done <= 1'b1;
            end
            else
                idx <= idx + 1'b1;   // req stays up for next byte
        end
        else if (!boot_done && !boot_req)
            boot_req <= 1'b1;   // first read right out of reset
    end

endmodule

/* src/eeprom_arbiter.sv */
`timescale 1ns/100ps
module eeprom_arbiter import i2c_pkg::*; (
    input  logic     CLK,
    input  logic     RESET,
    input  logic     boot_req,
    input  logic     boot_rd,
    input  ee_addr_t boot_addr,
    input  ee_data_t boot_wdata,
    output logic     boot_done,
    input  logic     host_req,
    input  logic     host_rd,
    input  ee_addr_t host_addr,
    input  ee_data_t host_wdata,
    output logic     host_done,
    output logic     rsp_nack,
    output ee_data_t rsp_rdata,
    output logic     eng_start,
    output logic     eng_rd,
    output ee_addr_t eng_addr,
    output ee_data_t eng_wdata,
    input  logic     eng_done,
    input  logic     eng_nack,
    input  ee_data_t eng_rdata
);
    logic grant_boot;
    logic grant_host;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            grant_boot <= 1'b0;
            grant_host <= 1'b0;
            eng_start  <= 1'b0;
        end
        else
        begin
            eng_start <= 1'b0;
            if (eng_done)
            begin
                grant_boot <= 1'b0;
                grant_host <= 1'b0;
            end
            else if (!grant_boot && !grant_host)
            begin
                if (boot_req)   // boot loader wins
                begin
                    grant_boot <= 1'b1;
                    eng_start  <= 1'b1;
                end
                else if (host_req)
                begin
                    grant_host <= 1'b1;
                    eng_start  <= 1'b1;
                end
            end
        end
    end

    assign eng_rd    = grant_boot ? boot_rd    : host_rd;
    assign eng_addr  = grant_boot ? boot_addr  : host_addr;
    assign eng_wdata = grant_boot ? boot_wdata : host_wdata;

    assign boot_done = grant_boot && eng_done;
    assign host_done = grant_host && eng_done;
    assign rsp_nack  = eng_nack;    // only looked at with done
    assign rsp_rdata = eng_rdata;

    a_one_grant: assert property (@(posedge CLK) disable iff (RESET)
        !(grant_boot && grant_host))
        else $error("both requesters granted");

    a_done_granted: assert property (@(posedge CLK) disable iff (RESET)
        eng_done |-> (grant_boot || grant_host))
        else $error("engine done without a grant");

endmodule

/* src/eeprom_i2c_master.sv */
`timescale 1ns/100ps
module eeprom_i2c_master import i2c_pkg::*; #(
    parameter int SCL_HALF = 4
) (
    input  logic     CLK,
    input  logic     RESET,
    input  logic     start,
    input  logic     rd,
    input  ee_addr_t addr,
    input  ee_data_t wdata,
    input  logic     sda_in,
    output logic     scl,
    output logic     sda_drive_low,
    output logic     done,
    output logic     nack,
    output ee_data_t rdata
);
    localparam int CNT_W = $clog2(2 * SCL_HALF);
    localparam logic [CNT_W-1:0] CNT_LAST    = CNT_W'(2 * SCL_HALF - 1);
    localparam logic [CNT_W-1:0] CNT_HIGH    = CNT_W'(SCL_HALF);
    localparam logic [CNT_W-1:0] CNT_LOAD_LO = CNT_W'(SCL_HALF / 2 - 1);  // mid scl low
    localparam logic [CNT_W-1:0] CNT_LOAD_HI = CNT_W'(SCL_HALF + SCL_HALF / 2 - 1);
    localparam logic [CNT_W-1:0] CNT_SAMPLE  = CNT_W'(SCL_HALF + SCL_HALF / 2);

    i2c_state_e       state;
    logic [CNT_W-1:0] cnt;
    logic [3:0]       bit_cnt;
    ee_data_t         shreg;
    logic             rd_q;
    ee_addr_t         addr_q;
    ee_data_t         wdata_q;
    logic             nack_q;
    logic             send_phase;
    logic             start_phase;
    logic             phase_end;
    logic             ack_slot;

    assign send_phase  = state inside {ST_CTRL, ST_ADDR, ST_WDATA, ST_RCTRL};
    assign start_phase = state inside {ST_START, ST_RSTART};
    assign phase_end   = cnt == CNT_LAST;
    assign ack_slot    = bit_cnt == 4'd8;

    // bus idles high, start holds scl high while sda falls
    assign scl  = (state inside {ST_IDLE, ST_START, ST_DONE}) || cnt >= CNT_HIGH;
    assign done = state == ST_DONE;
    assign nack = nack_q;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state   <= ST_IDLE;
            cnt     <= '0;
            bit_cnt <= '0;
            nack_q  <= 1'b0;
        end
        else
        begin
            if (state == ST_IDLE || state == ST_DONE || phase_end)
                cnt <= '0;
            else
                cnt <= cnt + 1'b1;

            if ((send_phase || state == ST_RDATA) && phase_end)
                bit_cnt <= ack_slot ? 4'd0 : bit_cnt + 4'd1;

            if (state == ST_IDLE && start)
                nack_q <= 1'b0;
            else if (send_phase && ack_slot && cnt == CNT_SAMPLE && sda_in)
                nack_q <= 1'b1;   // no ack from slave

            case (state)
                ST_IDLE:   if (start) state <= ST_START;
                ST_START:  if (phase_end) state <= ST_CTRL;
                ST_CTRL:   if (phase_end && ack_slot) state <= nack_q ? ST_STOP : ST_ADDR;
                ST_ADDR:
                    if (phase_end && ack_slot)
                        state <= nack_q ? ST_STOP : (rd_q ? ST_RSTART : ST_WDATA);
                ST_WDATA:  if (phase_end && ack_slot) state <= ST_STOP;
                ST_RSTART: if (phase_end) state <= ST_RCTRL;
                ST_RCTRL:  if (phase_end && ack_slot) state <= nack_q ? ST_STOP : ST_RDATA;
                ST_RDATA:  if (phase_end && ack_slot) state <= ST_STOP;
                ST_STOP:   if (phase_end) state <= ST_DONE;
                default:   state <= ST_IDLE;   // done lasts one cycle
            endcase
        end
    end

    // request fields and shifter
    always_ff @(posedge CLK)
    begin
        if (state == ST_IDLE && start)
        begin
            rd_q    <= rd;
            addr_q  <= addr;
            wdata_q <= wdata;
        end

        if (state == ST_START && phase_end)
            shreg <= {EE_DEV_CODE, addr_q[10:8], 1'b0};
        else if (state == ST_RSTART && phase_end)
            shreg <= {EE_DEV_CODE, addr_q[10:8], 1'b1};
        else if (state == ST_CTRL && phase_end && ack_slot)
            shreg <= addr_q[7:0];
        else if (state == ST_ADDR && phase_end && ack_slot)
            shreg <= wdata_q;
        else if (state == ST_RDATA && cnt == CNT_SAMPLE && !ack_slot)
            shreg <= {shreg[6:0], sda_in};   // msb first
        else if (send_phase && phase_end)
            shreg <= {shreg[6:0], 1'b0};

        if (state == ST_RDATA && phase_end && ack_slot)
            rdata <= shreg;
        else if (send_phase && ack_slot && cnt == CNT_SAMPLE && sda_in)
            rdata <= 8'hFF;   // line left released
    end

    // sda moves mid scl low for bits, mid scl high for start and stop
    always_ff @(posedge CLK)
    begin
        if (RESET)
            sda_drive_low <= 1'b0;
        else if (cnt == CNT_LOAD_LO)
        begin
            if (send_phase)
                sda_drive_low <= !ack_slot && !shreg[7];
            else
                sda_drive_low <= state == ST_STOP;
        end
        else if (cnt == CNT_LOAD_HI)
        begin
            if (start_phase)
                sda_drive_low <= 1'b1;
            else if (state == ST_STOP)
                sda_drive_low <= 1'b0;
        end
    end

    a_done_pulse: assert property (@(posedge CLK) disable iff (RESET) done |=> !done)
        else $error("engine done longer than one cycle");

    a_sda_scl_low: assert property (@(posedge CLK) disable iff (RESET)
        $changed(sda_drive_low) && !(state inside {ST_START, ST_RSTART, ST_STOP}) |-> !scl)
        else $error("sda changed with scl high during a data bit");

endmodule

/* src/eeprom_sys_top.sv */
`timescale 1ns/100ps
module eeprom_sys_top import apb_pkg::*, i2c_pkg::*; #(
    parameter int SCL_HALF   = 4,
    parameter int BOOT_BYTES = 4
) (
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  apb_addr_t               paddr,
    input  apb_data_t               pwdata,
    output apb_data_t               prdata,
    output logic                    pready,
    output logic                    pslverr,
    output logic                    scl,
    inout  wire                     sda,
    output logic [BOOT_BYTES*8-1:0] boot_cfg,
    output logic                    boot_done
);
    logic     host_req, host_rd, host_done;
    ee_addr_t host_addr;
    ee_data_t host_wdata;
    logic     boot_req, boot_xfer_done;
    ee_addr_t boot_addr;
    logic     rsp_nack;
    ee_data_t rsp_rdata;
    logic     eng_start, eng_rd, eng_done, eng_nack;
    ee_addr_t eng_addr;
    ee_data_t eng_wdata, eng_rdata;
    logic     sda_drive_low;

    assign sda = sda_drive_low ? 1'b0 : 1'bz;   // open drain, pull-up outside

    apb_eeprom_regs apb_eeprom_regs_inst (
        .CLK(CLK), .RESET(RESET), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .host_req(host_req), .host_rd(host_rd),
        .host_addr(host_addr), .host_wdata(host_wdata), .host_done(host_done),
        .rsp_nack(rsp_nack), .rsp_rdata(rsp_rdata)
    );

    boot_loader #(.BOOT_BYTES(BOOT_BYTES)) boot_loader_inst (
        .CLK(CLK), .RESET(RESET), .boot_done_in(boot_xfer_done), .rsp_rdata(rsp_rdata),
        .boot_req(boot_req), .boot_addr(boot_addr), .boot_cfg(boot_cfg),
        .boot_done(boot_done)
    );

    // boot side only reads
    eeprom_arbiter eeprom_arbiter_inst (
        .CLK(CLK), .RESET(RESET),
        .boot_req(boot_req), .boot_rd(1'b1), .boot_addr(boot_addr),
        .boot_wdata(ee_data_t'(0)), .boot_done(boot_xfer_done),
        .host_req(host_req), .host_rd(host_rd), .host_addr(host_addr),
        .host_wdata(host_wdata), .host_done(host_done),
        .rsp_nack(rsp_nack), .rsp_rdata(rsp_rdata),
        .eng_start(eng_start), .eng_rd(eng_rd), .eng_addr(eng_addr),
        .eng_wdata(eng_wdata), .eng_done(eng_done), .eng_nack(eng_nack),
        .eng_rdata(eng_rdata)
    );

    eeprom_i2c_master #(.SCL_HALF(SCL_HALF)) eeprom_i2c_master_inst (
        .CLK(CLK), .RESET(RESET), .start(eng_start), .rd(eng_rd), .addr(eng_addr),
        .wdata(eng_wdata), .sda_in(sda), .scl(scl), .sda_drive_low(sda_drive_low),
        .done(eng_done), .nack(eng_nack), .rdata(eng_rdata)
    );

endmodule

/* src/i2c_pkg.sv */
package i2c_pkg;

    // 24C16 style addressing, 2048 bytes
    typedef logic [10:0] ee_addr_t;
    typedef logic [7:0]  ee_data_t;

    localparam logic [3:0] EE_DEV_CODE = 4'b1010;   // fixed part of control byte

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_START,
        ST_CTRL,
        ST_ADDR,
        ST_WDATA,
        ST_RSTART,
        ST_RCTRL,
        ST_RDATA,
        ST_STOP,
        ST_DONE
    } i2c_state_e;

endpackage

/* test/eeprom_model.sv */
`timescale 1ns/100ps
module eeprom_model (
    input  logic scl,
    inout  wire  sda,
    input  logic busy,
    output logic proto_err
);
    typedef enum logic [1:0] {B_CTRL, B_ADDR, B_DATA} byte_e;

    logic [7:0]  mem [0:2047];
    logic [7:0]  shreg;
    logic [7:0]  tx;
    logic [10:0] ptr;
    logic [3:0]  bit_cnt;
    logic        active;
    logic        sending;
    logic        drive_low;
    byte_e       which;

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'ha5 ^ i[7:0] ^ {i[10:8], 5'b0};   // same rule as the tb mirror
        active    = 1'b0;
        sending   = 1'b0;
        drive_low = 1'b0;
        bit_cnt   = '0;
        ptr       = '0;
        which     = B_CTRL;
        proto_err = 1'b0;
    end

    // start or repeated start
    always @(negedge sda)
    begin
        if (scl === 1'b1)
        begin
            if (active && bit_cnt > 1)
                proto_err = 1'b1;   // sda moved inside a byte
            active    = 1'b1;
            sending   = 1'b0;
            bit_cnt   = '0;
            which     = B_CTRL;
            drive_low = 1'b0;
        end
    end

    // stop
    always @(posedge sda)
    begin
        if (scl === 1'b1)
        begin
            if (active && bit_cnt > 1)
                proto_err = 1'b1;
            active = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        if (active)
        begin
            if (!sending && bit_cnt < 8)
                shreg = {shreg[6:0], sda};
            bit_cnt = bit_cnt + 1'b1;
        end
    end

    always @(negedge scl)
    begin
        if (active)
        begin
            if (bit_cnt == 8 && !sending)
            begin
                if (busy || (which == B_CTRL && shreg[7:4] != 4'b1010))
                begin
                    active    = 1'b0;   // leave the ack slot released
                    drive_low = 1'b0;
                end
                else
                begin
                    case (which)
                        B_CTRL:
                        begin
                            ptr[10:8] = shreg[3:1];
                            sending   = shreg[0];
                            tx        = mem[{shreg[3:1], ptr[7:0]}];
                        end
                        B_ADDR:  ptr[7:0] = shreg;
                        default: mem[ptr] = shreg;
                    endcase
                    which     = (which == B_CTRL) ? B_ADDR : B_DATA;
                    drive_low = 1'b1;   // ack
                end
            end
            else if (bit_cnt == 8)
            begin
                drive_low = 1'b0;   // master nacks, then stop
                active    = 1'b0;
            end
            else if (bit_cnt == 9)
            begin
                bit_cnt   = '0;
                drive_low = sending && !tx[7];
            end
            else if (sending)
                drive_low = !tx[7 - bit_cnt];
            else
                drive_low = 1'b0;
        end
    end

endmodule

/* test/tb_eeprom_sys.sv */
`timescale 1ns/100ps
module tb_eeprom_sys import apb_pkg::*, i2c_pkg::*;;
    localparam int SCL_HALF   = 4;
    localparam int BOOT_BYTES = 4;
    localparam int N_XFER     = 24;                        // boot reads plus host commands
    localparam int XFER_NS    = 45 * 2 * SCL_HALF * 20;    // worst case random read
    localparam int TIMEOUT_NS = N_XFER * XFER_NS + 20000;

    logic                    CLK;
    logic                    RESET;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    apb_addr_t               paddr;
    apb_data_t               pwdata;
    apb_data_t               prdata;
    logic                    pready;
    logic                    pslverr;
    logic                    scl;
    tri1                     sda;
    logic [BOOT_BYTES*8-1:0] boot_cfg;
    logic [BOOT_BYTES*8-1:0] boot_exp;
    logic                    boot_done;
    logic                    ee_busy;
    logic                    proto_err;
    ee_data_t                mirror [0:2047];
    integer                  seed;
    int                      check_errors;
    int                      proto_errors;
    logic                    chk_en;
    string                   chk_name;
    logic [31:0]             chk_exp;
    logic [31:0]             chk_got;

    eeprom_sys_top #(.SCL_HALF(SCL_HALF), .BOOT_BYTES(BOOT_BYTES)) eeprom_sys_top_inst (
        .CLK(CLK), .RESET(RESET), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .scl(scl), .sda(sda), .boot_cfg(boot_cfg), .boot_done(boot_done)
    );

    eeprom_model eeprom_model_inst (.scl(scl), .sda(sda), .busy(ee_busy), .proto_err(proto_err));

    initial
    begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    initial
    begin
        #(TIMEOUT_NS);
        $display("run timed out after %0d ns, a command never finished", TIMEOUT_NS);
        $display("TEST FAILED");
        $finish;
    end

    a_check: assert property (@(posedge CLK) chk_en |-> chk_got == chk_exp)
        else
        begin
            check_errors++;
            $display("CHECK FAILED at %0t: %s expected %0h actual %0h",
                     $time, chk_name, chk_exp, chk_got);
        end

    a_boot_cfg: assert property (@(posedge CLK) disable iff (RESET)
        $rose(boot_done) |-> boot_cfg == boot_exp)
        else
        begin
            check_errors++;
            $display("CHECK FAILED at %0t: boot_cfg expected %0h actual %0h",
                     $time, boot_exp, boot_cfg);
        end

    // no wait states, every access phase is ready
    a_pready: assert property (@(posedge CLK) disable iff (RESET)
        psel && penable |-> pready)
        else
        begin
            check_errors++;
            $display("CHECK FAILED at %0t: pready expected 1 actual %0b", $time, pready);
        end

    a_protocol: assert property (@(posedge CLK) !$rose(proto_err))
        else
        begin
            proto_errors++;
            $display("EEPROM model saw SDA change while SCL was high inside a byte at %0t", $time);
        end

    function automatic ee_data_t fill_byte(ee_addr_t a);
        return 8'ha5 ^ a[7:0] ^ {a[10:8], 5'b0};
    endfunction

    task automatic check_value(string name, logic [31:0] exp, logic [31:0] got);
        @(negedge CLK);
        chk_name = name;
        chk_exp  = exp;
        chk_got  = got;
        chk_en   = 1'b1;
        @(negedge CLK);
        chk_en = 1'b0;
    endtask

    // one APB transfer without wait states
    task automatic apb_access(logic wr, apb_addr_t a, apb_data_t d,
                              output apb_data_t rd, output logic err);
        @(posedge CLK);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= a;
        pwdata  <= d;
        @(posedge CLK);
        penable <= 1'b1;
        @(negedge CLK);
        rd  = prdata;
        err = pslverr;
        @(posedge CLK);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic start_command(logic rd, ee_addr_t a, ee_data_t d);
        apb_data_t dummy;
        logic      err;
        apb_access(1'b1, REG_ADDR, apb_data_t'(a), dummy, err);
        apb_access(1'b1, REG_WDATA, apb_data_t'(d), dummy, err);
        apb_access(1'b1, REG_CMD, {30'b0, rd, 1'b1}, dummy, err);
        check_value("pslverr", 0, err);
    endtask

    task automatic wait_idle(output apb_data_t st);
        logic err;
        do
            apb_access(1'b0, REG_STATUS, '0, st, err);
        while (st[0]);
    endtask

    task automatic finish_command(logic [2:0] exp_status);
        apb_data_t st;
        wait_idle(st);
        check_value("STATUS", exp_status, st);
        check_value("scl", 1, scl);   // bus released when idle
        check_value("sda", 1, sda);
    endtask

    task automatic write_byte(ee_addr_t a, ee_data_t d, logic [2:0] exp_status);
        start_command(1'b0, a, d);
        finish_command(exp_status);
        if (!exp_status[1])
            mirror[a] = d;
    endtask

    task automatic read_byte(ee_addr_t a);
        apb_data_t rd;
        logic      err;
        start_command(1'b1, a, 8'h00);
        finish_command(3'b100);
        apb_access(1'b0, REG_RDATA, '0, rd, err);
        check_value("RDATA", mirror[a], rd);
    endtask

    initial
    begin
        apb_data_t st;
        logic      err;
        ee_addr_t  a;
        ee_data_t  d;

        seed         = 32'h0bb42280;
        check_errors = 0;
        proto_errors = 0;
        chk_en       = 1'b0;
        RESET        = 1'b1;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        ee_busy      = 1'b0;
        for (int i = 0; i < 2048; i++)
            mirror[i] = fill_byte(ee_addr_t'(i));
        for (int i = 0; i < BOOT_BYTES; i++)
            boot_exp[i*8 +: 8] = fill_byte(ee_addr_t'(i));

        repeat (8) @(posedge CLK);
        RESET <= 1'b0;

        // host go while boot reads still own the engine
        a = ee_addr_t'($random(seed));
        d = ee_data_t'($random(seed));
        start_command(1'b0, a, d);
        apb_access(1'b0, REG_STATUS, '0, st, err);
        check_value("STATUS.busy", 1, st[0]);
        check_value("boot_done", 0, boot_done);
        apb_access(1'b1, REG_CMD, 32'h3, st, err);
        check_value("pslverr", 1, err);
        wait_idle(st);
        check_value("boot_done", 1, boot_done);
        check_value("STATUS", 3'b100, st);
        mirror[a] = d;
        read_byte(a);

        // random addresses, upper block bits walk 0 to 5
        for (int i = 0; i < 6; i++)
        begin
            a       = ee_addr_t'($random(seed));
            a[10:8] = 3'(i);
            d       = ee_data_t'($random(seed));
            write_byte(a, d, 3'b100);
            read_byte(a);
        end

        // device busy, write must nack and leave memory alone
        a = ee_addr_t'($random(seed));
        d = ~mirror[a];
        @(posedge CLK);
        ee_busy <= 1'b1;
        write_byte(a, d, 3'b110);
        @(posedge CLK);
        ee_busy <= 1'b0;
        read_byte(a);

        $display("check errors: %0d, protocol errors: %0d", check_errors, proto_errors);
        if (check_errors == 0 && proto_errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule
